/* compile.f */
logic/transpose_pkg.sv
logic/row_assembler.sv
logic/transpose_buffer.sv
logic/column_reducer.sv
logic/transpose_top.sv
dv/transpose_tb.sv

/* Bender.yml */
package:
  name: transpose

sources:
  - logic/transpose_pkg.sv
  - logic/row_assembler.sv
  - logic/transpose_buffer.sv
  - logic/column_reducer.sv
  - logic/transpose_top.sv
  - target: test
    files:
      - dv/transpose_tb.sv

/* dv/transpose_tb.sv */
/* random 4x4 matrices through transpose_top, checked against a reference queue
   stops at the first error, seed is fixed so every run sends the same stimulus */
module transpose_tb;

    import transpose_pkg::*;

    localparam int     n_rand_mats = 40;
    localparam int     n_mats_time = n_rand_mats + 2;   // plus fresh and dropped matrix
    localparam int     clk_period  = 100;
    localparam int     drive_dly   = 10;
    localparam longint timeout     = longint'(n_mats_time * dim * dim * 4 + 50) * clk_period;

    logic    clk;
    logic    rst_n;
    logic    elem_valid;
    elem_t   elem_data;
    logic    out_valid;
    result_t out;

    logic    mat_end;   // high with the 16th element of a matrix

    elem_t   ref_q [$];   // elements of the matrix being sent
    result_t exp_q [$];   // expected columns, in output order

    int          beat_cnt;
    int unsigned seed_ret;

    transpose_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .out_valid  (out_valid),
        .out        (out)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    // one clock of stimulus, applied just after the rising edge
    task automatic drive_cycle(input logic valid, input elem_t data, input logic last);
        @(posedge clk);
        #drive_dly;
        elem_valid = valid;
        elem_data  = data;
        mat_end    = last;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, elem_t'($urandom), 1'b0);   // data is junk, must be ignored
    endtask

    function automatic elem_t random_elem();
        elem_t e;
        if ($urandom % 8 == 0) begin
            e = 8'hff;   // pushes the sums toward their maximum
        end else begin
            e = elem_t'($urandom);
        end
        return e;
    endfunction

    // column j of the matrix is element j of every row
    task automatic push_expected();
        elem_t   m [dim][dim];
        result_t r;
        for (int i = 0; i < dim * dim; i++) begin
            m[i / dim][i % dim] = ref_q.pop_front();
        end
        for (int j = 0; j < dim; j++) begin
            r.data.e0 = m[0][j];
            r.data.e1 = m[1][j];
            r.data.e2 = m[2][j];
            r.data.e3 = m[3][j];
            r.sum     = '0;
            for (int k = 0; k < dim; k++) begin
                r.sum = r.sum + {{(sum_w - elem_w){1'b0}}, m[k][j]};
            end
            r.last = (j == dim - 1);
            exp_q.push_back(r);
        end
    endtask

    task automatic send_elem(input elem_t e);
        logic last;
        ref_q.push_back(e);
        last = (ref_q.size() == dim * dim);
        drive_cycle(1'b1, e, last);
        if (last) begin
            push_expected();
        end
    endtask

    task automatic send_matrix(input bit no_gaps);
        int gap;
        for (int i = 0; i < dim * dim; i++) begin
            gap = no_gaps ? 0 : int'($urandom % 4);
            repeat (gap) idle_cycle();
            send_elem(random_elem());
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
    endtask

    // partial matrix, then reset lands in the middle of it
    task automatic reset_mid_matrix(input int n_elems);
        for (int i = 0; i < n_elems; i++) begin
            send_elem(random_elem());
        end
        @(posedge clk);
        #drive_dly;
        elem_valid = 1'b0;
        mat_end    = 1'b0;
        rst_n      = 1'b0;
        ref_q.delete();
        exp_q.delete();
        repeat (3) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin : check_out
        result_t exp_r;
        if (!rst_n) begin
            beat_cnt = 0;
        end else if (out_valid) begin
            if (exp_q.size() == 0) begin
                report_error("out_valid high although no full matrix was sent since reset");
            end else begin
                exp_r = exp_q.pop_front();
                assert (out.data === exp_r.data)
                    else report_error($sformatf("Mismatch out.data: expected %h, got %h",
                                                exp_r.data, out.data));
                assert (out.sum === exp_r.sum)
                    else report_error($sformatf("Mismatch out.sum: expected %h, got %h",
                                                exp_r.sum, out.sum));
                assert (out.last === (beat_cnt == dim - 1))
                    else report_error($sformatf("Mismatch out.last: expected %h, got %h",
                                                (beat_cnt == dim - 1), out.last));
                if (out.last) begin
                    beat_cnt = 0;
                end else begin
                    beat_cnt++;
                end
            end
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else report_error("out_valid high while reset is asserted");

    // last element sampled at edge k, first column out after edge k+3
    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (elem_valid && mat_end) |-> ##4 $rose(out_valid))
        else report_error("first column did not come three cycles after the last element");

    a_burst_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out.last) |=> out_valid)
        else report_error("out_valid dropped inside the columns of one matrix");

    a_burst_closed: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out.last) |=> !out_valid)
        else report_error("out_valid stayed high after the last column");

    initial begin : watchdog
        #(timeout);
        report_error("timeout, the run took longer than the tests allow");
    end

    initial begin : stimulus
        seed_ret   = $urandom(25);
        rst_n      = 1'b0;
        elem_valid = 1'b0;
        elem_data  = '0;
        mat_end    = 1'b0;
        beat_cnt   = 0;

        repeat (10) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
        repeat (3) idle_cycle();

        // first few back to back with no gaps, rest mixed
        for (int m = 0; m < n_rand_mats; m++) begin
            send_matrix(m < 8 || ($urandom % 3 == 0));
        end
        drain();

        reset_mid_matrix(7);
        repeat (2) idle_cycle();
        send_matrix(1'b1);
        drain();

        $display("** PASS **");
        $finish;
    end

endmodule

/* logic/transpose_top.sv */
/* strobed elements in, transposed columns with sums out
   fixed latency, no handshake, matrix framing starts at reset */
module transpose_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   elem_valid,
    input  transpose_pkg::elem_t   elem_data,
    output logic                   out_valid,
    output transpose_pkg::result_t out
);

    import transpose_pkg::*;

    logic      row_valid;
    vec_t      row;
    logic      col_valid;
    col_beat_t col;

    // elements to rows
    row_assembler u_row_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .row_valid  (row_valid),
        .row        (row)
    );

    // rows to columns
    transpose_buffer u_transpose_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_valid (row_valid),
        .row       (row),
        .col_valid (col_valid),
        .col       (col)
    );

    // columns plus sums
    column_reducer u_column_reducer (
        .clk       (clk),
        .rst_n     (rst_n),
        .col_valid (col_valid),
        .col       (col),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

/* logic/column_reducer.sv */
/* registers each column with its zero-extended element sum
   one cycle of latency, no stall input */
module column_reducer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     col_valid,
    input  transpose_pkg::col_beat_t col,
    output logic                     out_valid,
    output transpose_pkg::result_t   out
);

    import transpose_pkg::*;

    logic [sum_w-1:0] col_sum;
    vec_t             data_q;
    logic [sum_w-1:0] sum_q;
    logic             last_q;

    // zero extend before adding, sum_w is wide enough for dim elements
    assign col_sum = sum_w'(col.data.e0)
                   + sum_w'(col.data.e1)
                   + sum_w'(col.data.e2)
                   + sum_w'(col.data.e3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            out_valid <= col_valid;
            last_q    <= col_valid && col.last;   // only with a live beat
        end
    end

    always_ff @(posedge clk) begin
        if (col_valid) begin
            data_q <= col.data;
            sum_q  <= col_sum;
        end
    end

    assign out = '{data: data_q, sum: sum_q, last: last_q};

    a_last_framed: assert property (@(posedge clk) disable iff (!rst_n)
        out.last |-> out_valid)
        else $error("out.last set without out_valid");

endmodule

/* logic/transpose_buffer.sv */
/* ping-pong store of two dim x dim matrices, written by rows, read by columns
   a read-out takes dim cycles and must end before the other bank fills */
module transpose_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     row_valid,
    input  transpose_pkg::vec_t      row,
    output logic                     col_valid,
    output transpose_pkg::col_beat_t col
);

    import transpose_pkg::*;

    vec_t bank [2][dim];   // [bank][row]

    // write side
    logic [idx_w-1:0] wr_row;
    logic             wr_bank;
    logic             swap;

    // read side
    logic             rd_active;
    logic             rd_bank;
    logic [idx_w-1:0] rd_col;
    logic             rd_end;
    vec_t             rd_vec;

    assign swap   = row_valid && (wr_row == idx_w'(dim-1));
    assign rd_end = (rd_col == idx_w'(dim-1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_row  <= '0;
            wr_bank <= 1'b0;
        end else if (row_valid) begin
            wr_row <= swap ? '0 : wr_row + 1'b1;
            if (swap) begin
                wr_bank <= ~wr_bank;   // last row in, hand bank to read side
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            bank[wr_bank][wr_row] <= row;
        end
    end

    // column rd_col is slot rd_col of every stored row
    always_comb begin
        rd_vec.e0 = elem_at(bank[rd_bank][0], rd_col);
        rd_vec.e1 = elem_at(bank[rd_bank][1], rd_col);
        rd_vec.e2 = elem_at(bank[rd_bank][2], rd_col);
        rd_vec.e3 = elem_at(bank[rd_bank][3], rd_col);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_bank   <= 1'b0;
            rd_col    <= '0;
            col_valid <= 1'b0;
        end else begin
            col_valid <= rd_active;
            if (swap) begin
                rd_active <= 1'b1;
                rd_bank   <= wr_bank;   // the bank that just filled
                rd_col    <= '0;
            end else if (rd_active) begin
                rd_col <= rd_col + 1'b1;
                if (rd_end) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_active) begin
            col <= '{data: rd_vec, idx: rd_col, last: rd_end};
        end
    end

    // next matrix must not complete while this one is still draining
    a_no_swap_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        swap |-> !rd_active)
        else $error("bank swap while a read-out is still active");

    a_col_burst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(col_valid) |-> col_valid [*dim] ##1 !col_valid)
        else $error("col_valid burst is not exactly dim cycles long");

endmodule

/* logic/row_assembler.sv */
/* row boundaries come from the slot counter only, which starts at reset
   at most one element per cycle, no back-pressure on row_valid */
module row_assembler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 elem_valid,
    input  transpose_pkg::elem_t elem_data,
    output logic                 row_valid,
    output transpose_pkg::vec_t  row
);

    import transpose_pkg::*;

    logic [idx_w-1:0] slot;       // elements already in row_sr
    vec_t             row_sr;     // partial row
    vec_t             row_next;
    logic             row_done;

    // new element enters at e3 and moves down,
    // so after dim shifts the first one lands in e0
    assign row_next = {elem_data, row_sr[dim*elem_w-1:elem_w]};
    assign row_done = elem_valid && (slot == idx_w'(dim-1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot      <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= row_done;   // one cycle pulse
            if (elem_valid) begin
                slot <= row_done ? '0 : slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (elem_valid) begin
            row_sr <= row_next;
        end
        // held until the next row completes, so stable under row_valid
        if (row_done) begin
            row <= row_next;
        end
    end

    a_row_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        row_valid |=> !row_valid)
        else $error("row_valid high for two cycles in a row");

endmodule

/* logic/transpose_pkg.sv */
/* sizes and payload types for the 4x4 transpose path, square matrices only
   slot 0 of a vec_t is the first element received and sits in the low byte */
package transpose_pkg;

    localparam int elem_w = 8;
    localparam int dim    = 4;    // rows == columns
    localparam int idx_w  = 2;    // row or column index
    localparam int sum_w  = 10;   // 4 * 255 fits

    typedef logic [elem_w-1:0] elem_t;

    // one row going in, or one column coming out
    typedef struct packed {
        elem_t e3;
        elem_t e2;
        elem_t e1;
        elem_t e0;   // first element received
    } vec_t;

    // buffer to consumer
    typedef struct packed {
        vec_t             data;
        logic [idx_w-1:0] idx;    // column number within the matrix
        logic             last;   // column dim-1
    } col_beat_t;

    // consumer to outside
    typedef struct packed {
        vec_t             data;
        logic [sum_w-1:0] sum;
        logic             last;
    } result_t;

    // pick slot i of a row or column
    function automatic elem_t elem_at(vec_t v, logic [idx_w-1:0] i);
        elem_t e;
        case (i)
            2'd0:    e = v.e0;
            2'd1:    e = v.e1;
            2'd2:    e = v.e2;
            default: e = v.e3;
        endcase
        return e;
    endfunction

endpackage
